// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_dsp -f verilog.f
	@out=$$(./obj_dir/Vtb_rx_dsp); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir

// File: code_buffer.sv
`timescale 1ns/1ps

module code_buffer
    import dsp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  code_word_t codes_in,
    output code_word_t cur_word,
    output code_word_t prev_word
);

    // Two-word history window, newest in cur_word
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_word  <= '0;
            prev_word <= '0;
        end else begin
            cur_word  <= codes_in;
            prev_word <= cur_word;
        end
    end

endmodule

// File: dsp_config_regs.sv
`timescale 1ns/1ps

module dsp_config_regs
    import dsp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cfg_req,
    input  cfg_req_t cfg_payload,
    output logic     cfg_ack,
    output dsp_cfg_t cfg
);

    logic start;
    logic [thresh_bits-1:0] thresh_ext;

    assign start = cfg_req && !cfg_ack;

    // Sign-extend the short threshold field
    assign thresh_ext = {
        {(thresh_bits - cfg_thresh_bits){cfg_payload.word.ctrl_view.thresh[cfg_thresh_bits-1]}},
        cfg_payload.word.ctrl_view.thresh
    };

    // Four-phase acknowledge
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_ack <= 1'b0;
        end else if (start) begin
            cfg_ack <= 1'b1;
        end else if (!cfg_req) begin
            cfg_ack <= 1'b0;
        end
    end

    // Write lands on the edge that raises cfg_ack
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg <= '0;
        end else if (start) begin
            if (cfg_payload.kind) begin
                cfg.shift     <= cfg_payload.word.ctrl_view.shift;
                cfg.thresh    <= thresh_ext;
                cfg.align_pos <= cfg_payload.word.ctrl_view.align_pos;
            end else if (cfg_payload.word.weight_view.tap < taps) begin
                // Tap index beyond the FFE length is ignored
                cfg.weight[cfg_payload.word.weight_view.tap] <=
                    cfg_payload.word.weight_view.weight;
            end
        end
    end

endmodule

// File: dsp_pkg.sv
package dsp_pkg;

    localparam int lanes       = 4;
    localparam int code_bits   = 8;
    // FFE length, no larger than lanes
    localparam int taps        = 3;
    localparam int weight_bits = 8;
    localparam int est_bits    = 12;
    localparam int shift_bits  = 4;
    localparam int thresh_bits = 12;
    localparam int pos_bits    = 2;

    // Threshold as carried in a control write
    localparam int cfg_thresh_bits = 10;

    typedef struct packed {
        logic                             valid;
        logic [lanes-1:0][code_bits-1:0]  code;
    } code_word_t;

    typedef struct packed {
        logic                             valid;
        logic [lanes-1:0][est_bits-1:0]   value;
    } est_word_t;

    typedef struct packed {
        logic                             valid;
        logic [lanes-1:0]                 slice;
    } bit_word_t;

    typedef union packed {
        struct packed {
            logic [1:0]                   tap;
            logic [5:0]                   spare;
            logic [weight_bits-1:0]       weight;
        } weight_view;
        struct packed {
            logic [shift_bits-1:0]        shift;
            logic [cfg_thresh_bits-1:0]   thresh;
            logic [pos_bits-1:0]          align_pos;
        } ctrl_view;
    } cfg_word_u;

    typedef struct packed {
        // 0 writes one weight, 1 writes shift, threshold and offset
        logic                             kind;
        cfg_word_u                        word;
    } cfg_req_t;

    typedef struct packed {
        logic [taps-1:0][weight_bits-1:0] weight;
        logic [shift_bits-1:0]            shift;
        logic [thresh_bits-1:0]           thresh;
        logic [pos_bits-1:0]              align_pos;
    } dsp_cfg_t;

endpackage

// File: ffe_datapath.sv
`timescale 1ns/1ps

module ffe_datapath
    import dsp_pkg::*;
#(
    parameter int pipe_extra = 0
) (
    input  logic       clk,
    input  logic       rst,
    input  code_word_t cur_word,
    input  code_word_t prev_word,
    input  dsp_cfg_t   cfg,
    output est_word_t  est
);

    // Full product width plus growth for the tap sum
    localparam int acc_bits = code_bits + weight_bits + $clog2(taps);

    localparam logic signed [acc_bits-1:0] est_max = 2 ** (est_bits - 1) - 1;
    localparam logic signed [acc_bits-1:0] est_min = -(2 ** (est_bits - 1));

    logic signed [code_bits-1:0] serial [2*lanes];
    logic signed [acc_bits-1:0]  acc     [lanes];
    logic signed [acc_bits-1:0]  shifted [lanes];
    logic signed [est_bits-1:0]  sat     [lanes];

    est_word_t stage [pipe_extra+1];

    // Previous word first, lane 0 earliest
    always_comb begin
        for (int j = 0; j < lanes; j++) begin
            serial[j]         = prev_word.code[j];
            serial[lanes + j] = cur_word.code[j];
        end
    end

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            acc[i] = '0;
            for (int k = 0; k < taps; k++) begin
                acc[i] = acc[i] + $signed(cfg.weight[k]) * serial[lanes + i - k];
            end
            shifted[i] = acc[i] >>> cfg.shift;
            if (shifted[i] > est_max) begin
                sat[i] = est_max[est_bits-1:0];
            end else if (shifted[i] < est_min) begin
                sat[i] = est_min[est_bits-1:0];
            end else begin
                sat[i] = shifted[i][est_bits-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s <= pipe_extra; s++) begin
                stage[s] <= '0;
            end
        end else begin
            stage[0].valid <= cur_word.valid;
            for (int i = 0; i < lanes; i++) begin
                stage[0].value[i] <= sat[i];
            end
            // Extra retiming stages
            for (int s = 1; s <= pipe_extra; s++) begin
                stage[s] <= stage[s-1];
            end
        end
    end

    assign est = stage[pipe_extra];

endmodule

// File: rx_dsp_sva.sv
`timescale 1ns/1ps

module rx_dsp_sva
    import dsp_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic       cfg_req,
    input cfg_req_t   cfg_payload,
    input logic       cfg_ack,
    input code_word_t codes_in,
    input bit_word_t  bits_out
);

    payload_stable: assert property (@(posedge clk) disable iff (rst)
        cfg_req && $past(cfg_req) |-> $stable(cfg_payload))
        else $error("cfg_payload changed while cfg_req was high");

    ack_rise: assert property (@(posedge clk) disable iff (rst)
        $rose(cfg_ack) |-> $past(cfg_req))
        else $error("cfg_ack rose without a request");

    ack_fall: assert property (@(posedge clk) disable iff (rst)
        $fell(cfg_ack) |-> !$past(cfg_req))
        else $error("cfg_ack fell while cfg_req was still high");

    // Four cycles from codes_in to bits_out
    bits_latency: assert property (@(posedge clk) disable iff (rst)
        codes_in.valid |-> ##4 bits_out.valid)
        else $error("bits_out not valid four cycles after codes_in");

endmodule

bind rx_dsp_top rx_dsp_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .cfg_req     (cfg_req),
    .cfg_payload (cfg_payload),
    .cfg_ack     (cfg_ack),
    .codes_in    (codes_in),
    .bits_out    (bits_out)
);

// File: rx_dsp_top.sv
`timescale 1ns/1ps

module rx_dsp_top
    import dsp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_req,
    input  cfg_req_t   cfg_payload,
    output logic       cfg_ack,
    input  code_word_t codes_in,
    output code_word_t codes_out,
    output est_word_t  est_out,
    output bit_word_t  bits_out
);

    localparam int ffe_pipe_extra = 0;

    dsp_cfg_t   cfg;
    code_word_t prev_word;

    dsp_config_regs i_cfg_regs (
        .clk         (clk),
        .rst         (rst),
        .cfg_req     (cfg_req),
        .cfg_payload (cfg_payload),
        .cfg_ack     (cfg_ack),
        .cfg         (cfg)
    );

    // Current word doubles as the delayed code output
    code_buffer i_code_buffer (
        .clk       (clk),
        .rst       (rst),
        .codes_in  (codes_in),
        .cur_word  (codes_out),
        .prev_word (prev_word)
    );

    ffe_datapath #(
        .pipe_extra (ffe_pipe_extra)
    ) i_ffe (
        .clk       (clk),
        .rst       (rst),
        .cur_word  (codes_out),
        .prev_word (prev_word),
        .cfg       (cfg),
        .est       (est_out)
    );

    slicer_aligner i_slicer (
        .clk  (clk),
        .rst  (rst),
        .est  (est_out),
        .cfg  (cfg),
        .bits (bits_out)
    );

endmodule

// File: rx_dsp_vectors.hex
// [39:36] tag: 1 cfg write of [16:0], 2 code word [31:0] with expected bits_out [35:32]
// 4 random burst of [15:0] words, 0 end of records
1000000004
10000040FE
1000008001
1000010000
2F00FB140A
2B0803F605
2DFF0000EC
2200000000
// Larger tap 0, shift 2, threshold -60
1000000064
1000012F10
2FFF01807F
2D0000FEFD
2E007FC43C
2500000000
4000000010
1000010F11
4000000010
1000000006
1000012F13
4000000010
0000000000

// File: slicer_aligner.sv
`timescale 1ns/1ps

module slicer_aligner
    import dsp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  est_word_t est,
    input  dsp_cfg_t  cfg,
    output bit_word_t bits
);

    logic [lanes-1:0]   sliced;
    bit_word_t          new_word;
    logic [lanes-1:0]   old_slice;
    logic [2*lanes-1:0] window;

    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            sliced[i] = ($signed(est.value[i]) >= $signed(cfg.thresh));
        end
    end

    // Older word sits in the low half, so bit j is serial sample j
    assign window = {new_word.slice, old_slice};

    always_ff @(posedge clk) begin
        if (rst) begin
            new_word  <= '0;
            old_slice <= '0;
            bits      <= '0;
        end else begin
            new_word.valid <= est.valid;
            new_word.slice <= sliced;
            old_slice      <= new_word.slice;
            bits.valid     <= new_word.valid;
            bits.slice     <= window[cfg.align_pos +: lanes];
        end
    end

endmodule

// File: tb_rx_dsp.sv
`timescale 1ns/1ps

module tb_rx_dsp
    import dsp_pkg::*;
();

    localparam int timeout = 40;
    localparam int est_max = 2 ** (est_bits - 1) - 1;
    localparam int est_min = -(2 ** (est_bits - 1));

    logic       clk = 1'b0;
    logic       rst;
    logic       cfg_req;
    cfg_req_t   cfg_payload;
    logic       cfg_ack;
    code_word_t codes_in;
    code_word_t codes_out;
    est_word_t  est_out;
    bit_word_t  bits_out;

    logic [39:0] vectors [64];
    integer      seed = 32'h0049_665c;

    // Reference model state, advanced with every driven word
    logic signed [weight_bits-1:0] weight [taps];
    int               shift;
    int               thresh;
    int               align_pos;
    code_word_t       last_word;
    logic [lanes-1:0] last_slice;
    est_word_t        est_q  [$];
    bit_word_t        bits_q [$];
    // Bit 4 set when the vector file gives the expected bits_out word
    logic [4:0]       file_q [$];

    rx_dsp_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .cfg_req     (cfg_req),
        .cfg_payload (cfg_payload),
        .cfg_ack     (cfg_ack),
        .codes_in    (codes_in),
        .codes_out   (codes_out),
        .est_out     (est_out),
        .bits_out    (bits_out)
    );

    always #10 clk = ~clk;

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_codes(string name, code_word_t got, code_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_est(string name, est_word_t got, est_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bits(string name, bit_word_t got, bit_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    // Sum of weight k times the sample k places earlier, shifted and saturated
    function automatic est_word_t model_est(code_word_t prev_w, code_word_t cur_w);
        logic signed [code_bits-1:0] s [2*lanes];
        int        acc;
        est_word_t r;
        for (int j = 0; j < lanes; j++) begin
            s[j]         = prev_w.code[j];
            s[lanes + j] = cur_w.code[j];
        end
        r.valid = cur_w.valid;
        for (int i = 0; i < lanes; i++) begin
            acc = 0;
            for (int k = 0; k < taps; k++) begin
                acc += weight[k] * s[lanes + i - k];
            end
            acc = acc >>> shift;
            if (acc > est_max) begin
                acc = est_max;
            end else if (acc < est_min) begin
                acc = est_min;
            end
            r.value[i] = acc[est_bits-1:0];
        end
        return r;
    endfunction

    // Check outputs at the falling edge, then drive the next word
    task automatic step(code_word_t w, logic [4:0] file_exp);
        est_word_t          e;
        bit_word_t          b;
        logic [lanes-1:0]   sl;
        logic [2*lanes-1:0] win;
        logic [4:0]         fe;
        @(negedge clk);
        check_codes("codes_out", codes_out, last_word);
        if (est_out.valid) begin
            if (est_q.size() == 0) abort_run("est_out went valid with no word in flight");
            check_est("est_out", est_out, est_q.pop_front());
        end
        if (bits_out.valid) begin
            if (bits_q.size() == 0) abort_run("bits_out went valid with no word in flight");
            check_bits("bits_out", bits_out, bits_q.pop_front());
            fe = file_q.pop_front();
            if (fe[4]) begin
                b.valid = 1'b1;
                b.slice = fe[lanes-1:0];
                check_bits("bits_out", bits_out, b);
            end
        end
        codes_in <= w;
        e = model_est(last_word, w);
        for (int i = 0; i < lanes; i++) begin
            sl[i] = ($signed(e.value[i]) >= thresh);
        end
        // Older word first in the serial order
        win     = {sl, last_slice};
        b.valid = w.valid;
        b.slice = win[align_pos +: lanes];
        if (w.valid) begin
            est_q.push_back(e);
            bits_q.push_back(b);
            file_q.push_back(file_exp);
        end
        last_word  = w;
        last_slice = sl;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (est_q.size() != 0 || bits_q.size() != 0) begin
            if (t == timeout) abort_run("Timeout waiting for the pipeline to drain");
            step('0, 5'h0);
            t++;
        end
    endtask

    task automatic cfg_write(cfg_req_t p);
        int t;
        @(negedge clk);
        cfg_payload <= p;
        cfg_req     <= 1'b1;
        for (t = 0; !cfg_ack; t++) begin
            if (t == timeout) abort_run("Timeout waiting for cfg_ack to rise");
            @(negedge clk);
        end
        cfg_req <= 1'b0;
        for (t = 0; cfg_ack; t++) begin
            if (t == timeout) abort_run("Timeout waiting for cfg_ack to fall");
            @(negedge clk);
        end
        if (p.kind) begin
            shift     = p.word.ctrl_view.shift;
            thresh    = $signed(p.word.ctrl_view.thresh);
            align_pos = p.word.ctrl_view.align_pos;
        end else if (p.word.weight_view.tap < taps) begin
            weight[p.word.weight_view.tap] = p.word.weight_view.weight;
        end
    endtask

    initial begin
        logic [39:0] rec;
        code_word_t  w;
        int          idx;
        rst         = 1'b1;
        cfg_req     = 1'b0;
        cfg_payload = '0;
        codes_in    = '0;
        last_word   = '0;
        last_slice  = '0;
        shift       = 0;
        thresh      = 0;
        align_pos   = 0;
        for (int k = 0; k < taps; k++) begin
            weight[k] = '0;
        end
        $readmemh("rx_dsp_vectors.hex", vectors);
        repeat (16) @(negedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_codes("codes_out", codes_out, '0);
        check_est("est_out", est_out, '0);
        check_bits("bits_out", bits_out, '0);
        if (cfg_ack !== 1'b0) abort_run("cfg_ack is not low after reset");
        idx = 0;
        rec = vectors[0];
        while (rec[39:36] !== 4'h0) begin
            case (rec[39:36])
                4'h1: begin
                    drain();
                    cfg_write(rec[16:0]);
                    step('0, 5'h0);
                end
                4'h2: begin
                    w.valid = 1'b1;
                    w.code  = rec[31:0];
                    step(w, {1'b1, rec[35:32]});
                end
                4'h4: begin
                    repeat (rec[15:0]) begin
                        w.valid = 1'b1;
                        w.code  = $random(seed);
                        step(w, 5'h0);
                    end
                end
                default: abort_run("Unknown record tag in the vector file");
            endcase
            idx++;
            rec = vectors[idx];
        end
        drain();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog.f
dsp_pkg.sv
code_buffer.sv
ffe_datapath.sv
slicer_aligner.sv
dsp_config_regs.sv
rx_dsp_top.sv
rx_dsp_sva.sv
tb_rx_dsp.sv
